/* dv/vga_paddle_assertions.sv */
// VGA paddle checks
// sync pulse width, blanking colour and paddle position range,
// bound into the display top level

`timescale 1ns/100ps
`default_nettype none

`include "vga_defines.svh"

module vga_paddle_assertions (
  input logic          pclk,
  input logic          rst,
  input logic          hsync,
  input logic          hblnk,
  input logic          vblnk,
  input vga_pkg::rgb_t rgb,
  input logic [10:0]   xpos
);

  // clocks that hsync has been high so far
  int hs_len;
  // failed assertions so far
  int fail_count = 0;

  always_ff @(posedge pclk) begin
    if (rst) begin
      hs_len <= 0;
    end else if (hsync) begin
      hs_len <= hs_len + 1;
    end else begin
      hs_len <= 0;
    end
  end

  // --------------------------------------------------
  hsync_width: assert property (@(posedge pclk) disable iff (rst)
    $fell(hsync) |-> hs_len == `VGA_H_SYNC)
    else begin
      $error("hsync pulse lasted %0d clocks", hs_len);
      fail_count++;
    end

  blank_colour: assert property (@(posedge pclk) disable iff (rst)
    (hblnk || vblnk) |-> rgb == `COLOR_BLANK)
    else begin
      $error("colour %0h shown while blanking", rgb);
      fail_count++;
    end

  xpos_range: assert property (@(posedge pclk) disable iff (rst)
    xpos >= `XPOS_MIN && xpos <= `XPOS_MAX)
    else begin
      $error("paddle position %0d outside its window", xpos);
      fail_count++;
    end

endmodule

bind vga_paddle_top vga_paddle_assertions i_assertions (
  .pclk  (pclk),
  .rst   (rst),
  .hsync (hsync),
  .hblnk (vga_rect.hblnk),
  .vblnk (vga_rect.vblnk),
  .rgb   (rgb),
  .xpos  (xpos)
);

`default_nettype wire

/* dv/vga_paddle_tb.sv */
// VGA paddle testbench
// directed tests for sync timing, the reset picture, button stepping,
// clamping and the once per frame position latch

`timescale 1ns/100ps
`default_nettype none

`include "vga_defines.svh"

module vga_paddle_tb;

  localparam int step_div   = 100;
  localparam int scan_row   = `RECT_YPOS + 10;
  localparam int frame_len  = `VGA_H_TOTAL * `VGA_V_TOTAL;
  // the tests need a little under seven frames
  localparam int max_cycles = 8 * frame_len;

  logic          pclk;
  logic          rst;
  logic          left;
  logic          right;
  logic          hsync;
  logic          vsync;
  vga_pkg::rgb_t rgb;
  logic [10:0]   hcount;
  logic [10:0]   vcount;
  logic [10:0]   xpos;

  integer        seed = 32'h5b8bde77;
  int            errors = 0;
  int            checks = 0;
  int            cycles = 0;
  int            assert_fails;
  int            exp_xpos;
  int            edge_first;
  int            edge_last;
  vga_pkg::rgb_t pix_row0;
  vga_pkg::rgb_t pix_col0;
  vga_pkg::rgb_t pix_inner;

  vga_paddle_top #(
    .step_div (step_div)
  ) i_dut (
    .pclk   (pclk),
    .rst    (rst),
    .left   (left),
    .right  (right),
    .hsync  (hsync),
    .vsync  (vsync),
    .rgb    (rgb),
    .hcount (hcount),
    .vcount (vcount),
    .xpos   (xpos)
  );

  always #2 pclk = ~pclk;

  // watchdog
  always @(posedge pclk) begin
    cycles = cycles + 1;
    if (cycles >= max_cycles) begin
      $display("timeout: run did not finish within %0d clocks", max_cycles);
      $display("FAIL: see errors above");
      $finish;
    end
  end

  // --------------------------------------------------
  // helpers
  task automatic check_equal(input string what, input int got, input int exp);
    checks++;
    assert (got == exp) else begin
      errors++;
      $display("CHECK FAILED at %0t: %s is %0d (0x%0h), expected %0d (0x%0h)",
               $time, what, got, got, exp, exp);
    end
  endtask

  function automatic int clamp_xpos(input int pos);
    if (pos < `XPOS_MIN) return `XPOS_MIN;
    if (pos > `XPOS_MAX) return `XPOS_MAX;
    return pos;
  endfunction

  // hold the levels over len rising edges, then release and idle
  task automatic hold_buttons(input logic l, input logic r, input int len);
    int steps;
    left  = l;
    right = r;
    repeat (len) @(negedge pclk);
    left  = 1'b0;
    right = 1'b0;
    steps = (l != r) ? (len - 1) / step_div : 0;
    if (l && !r) exp_xpos = clamp_xpos(exp_xpos - steps);
    if (r && !l) exp_xpos = clamp_xpos(exp_xpos + steps);
    repeat (4) @(negedge pclk);
  endtask

  task automatic wait_frame_start();
    do begin
      @(negedge pclk);
    end while (hcount != 0 || vcount != 0);
  endtask

  // paddle columns on the scan row, plus background probes when
  // the scan starts at the top of a frame
  task automatic scan_rect_row(input bit from_frame_start);
    edge_first = -1;
    edge_last  = -1;
    if (from_frame_start) wait_frame_start();
    while (!(vcount == scan_row && hcount == 0)) begin
      if (vcount == 0 && hcount == 100) pix_row0 = rgb;
      if (vcount == 100 && hcount == 0) pix_col0 = rgb;
      if (vcount == 300 && hcount == 200) pix_inner = rgb;
      @(negedge pclk);
    end
    while (vcount == scan_row) begin
      if (rgb == `COLOR_RECT) begin
        if (edge_first < 0) edge_first = hcount;
        edge_last = hcount;
      end
      @(negedge pclk);
    end
  endtask

  task automatic check_edges(input string what, input int x);
    check_equal({what, " left edge"}, edge_first, x);
    check_equal({what, " right edge"}, edge_last, x + `RECT_WIDTH - 1);
  endtask

  // --------------------------------------------------
  // directed tests
  task automatic sync_timing();
    int   n = 0;
    int   hs_last = -1;
    int   hs_rises = 0;
    int   vs_first = -1;
    int   vs_span = -1;
    int   bad_period = 0;
    int   bad_blank = 0;
    logic hs_prev = 1'b0;
    logic vs_prev = 1'b0;
    while (vs_span < 0 && n < 3 * frame_len) begin
      @(negedge pclk);
      n++;
      if (hsync && !hs_prev) begin
        if (hs_last >= 0 && n - hs_last != `VGA_H_TOTAL) bad_period++;
        // lines inside the measured frame
        if (vs_first >= 0) hs_rises++;
        hs_last = n;
      end
      if (vsync && !vs_prev) begin
        if (vs_first < 0) vs_first = n;
        else vs_span = n - vs_first;
      end
      if ((hcount >= `VGA_H_ACTIVE || vcount >= `VGA_V_ACTIVE) && rgb != `COLOR_BLANK)
        bad_blank++;
      hs_prev = hsync;
      vs_prev = vsync;
    end
    check_equal("hsync periods other than a line", bad_period, 0);
    check_equal("lines between vsync rises", hs_rises, `VGA_V_TOTAL);
    check_equal("clocks between vsync rises", vs_span, frame_len);
    check_equal("coloured pixels while blanking", bad_blank, 0);
  endtask

  task automatic reset_picture();
    check_equal("xpos after reset", xpos, `XPOS_RESET);
    scan_rect_row(1'b1);
    check_edges("reset paddle", `XPOS_RESET);
    check_equal("row 0 colour", pix_row0, `COLOR_BORDER);
    check_equal("column 0 colour", pix_col0, `COLOR_BORDER);
    check_equal("interior colour", pix_inner, `COLOR_BG);
  endtask

  task automatic button_stepping();
    int len;
    int start;
    len   = 300 + ($unsigned($random(seed)) % 1201);
    start = exp_xpos;
    hold_buttons(1'b0, 1'b1, len);
    check_equal("xpos after right hold", xpos, start + (len - 1) / step_div);
    hold_buttons(1'b1, 1'b0, len);
    check_equal("xpos after left hold", xpos, start);
  endtask

  task automatic both_buttons();
    int start;
    start = exp_xpos;
    hold_buttons(1'b1, 1'b1, 1000);
    check_equal("xpos with both buttons", xpos, start);
  endtask

  task automatic range_clamping();
    int len;
    len = (`XPOS_MAX - `XPOS_MIN + 8) * step_div + 1;
    hold_buttons(1'b1, 1'b0, len);
    check_equal("xpos after long left hold", xpos, `XPOS_MIN);
    scan_rect_row(1'b1);
    check_edges("paddle at left limit", `XPOS_MIN);
    hold_buttons(1'b0, 1'b1, len);
    check_equal("xpos after long right hold", xpos, `XPOS_MAX);
    scan_rect_row(1'b1);
    check_edges("paddle at right limit", `XPOS_MAX);
  endtask

  task automatic frame_latch();
    int old_x;
    old_x = exp_xpos;
    wait_frame_start();
    while (vcount != 100) @(negedge pclk);
    // about two lines of holding, well above the scan row
    hold_buttons(1'b1, 1'b0, 20 * step_div + 1);
    check_equal("xpos after mid-frame hold", xpos, clamp_xpos(old_x - 20));
    scan_rect_row(1'b0);
    check_edges("paddle in the same frame", old_x);
    scan_rect_row(1'b1);
    check_edges("paddle in the next frame", clamp_xpos(old_x - 20));
  endtask

  // --------------------------------------------------
  initial begin
    pclk     = 1'b0;
    rst      = 1'b1;
    left     = 1'b0;
    right    = 1'b0;
    exp_xpos = `XPOS_RESET;
    repeat (10) @(negedge pclk);
    rst = 1'b0;
    sync_timing();
    reset_picture();
    button_stepping();
    both_buttons();
    range_clamping();
    frame_latch();
    assert_fails = i_dut.i_assertions.fail_count;
    $display("tests: 6, checks: %0d, errors: %0d, assertion failures: %0d",
             checks, errors, assert_fails);
    if (errors == 0 && assert_fails == 0) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

/* include/vga_defines.svh */
// VGA paddle constants
// screen timing for 800x600 at 40 MHz, paddle geometry, position limits
// and the 12-bit colours used by the painters

`ifndef VGA_DEFINES_SVH
`define VGA_DEFINES_SVH

// --------------------------------------------------
// horizontal timing, in pixels
`define VGA_H_ACTIVE 800
`define VGA_H_FP 40
`define VGA_H_SYNC 128
`define VGA_H_TOTAL 1056

// vertical timing, in lines
`define VGA_V_ACTIVE 600
`define VGA_V_FP 1
`define VGA_V_SYNC 4
`define VGA_V_TOTAL 628

// --------------------------------------------------
// paddle size and its fixed top row
`define RECT_WIDTH 48
`define RECT_HEIGHT 64
`define RECT_YPOS 500

// left edge limits, 80 pixels of margin on both sides
`define XPOS_MIN 80
`define XPOS_MAX 672
`define XPOS_RESET 376

// clocks per one pixel step
`define STEP_DIV_DEFAULT 20000

// colours as 12'hRGB
`define COLOR_BLANK 12'h000
`define COLOR_BG 12'h135
`define COLOR_BORDER 12'hfff
`define COLOR_RECT 12'hf80

`endif

/* sources.f */
+incdir+include
src/vga_pkg.sv
src/vga_timing.sv
src/draw_background.sv
src/position_rect_ctl.sv
src/draw_rect.sv
src/vga_paddle_top.sv
dv/vga_paddle_assertions.sv
dv/vga_paddle_tb.sv

/* src/draw_background.sv */
// Background painter
// fills the active area with the background colour, draws a one pixel
// frame on its edges and blanks everything else

`timescale 1ns/100ps
`default_nettype none

`include "vga_defines.svh"

module draw_background (
  input  logic               pclk,
  input  logic               rst,
  input  vga_pkg::vga_bus_t  vga_in,
  output vga_pkg::vga_bus_t  vga_out,
  output vga_pkg::rgb_t      rgb_out
);

  vga_pkg::rgb_t rgb_nxt;
  logic          on_border;

  // first and last active row and column
  assign on_border = (vga_in.hcount == 11'd0) ||
                     (vga_in.hcount == 11'(`VGA_H_ACTIVE - 1)) ||
                     (vga_in.vcount == 11'd0) ||
                     (vga_in.vcount == 11'(`VGA_V_ACTIVE - 1));

  always_comb begin
    if (vga_in.hblnk || vga_in.vblnk) begin
      rgb_nxt = `COLOR_BLANK;
    end else if (on_border) begin
      rgb_nxt = `COLOR_BORDER;
    end else begin
      rgb_nxt = `COLOR_BG;
    end
  end

  // --------------------------------------------------
  // one stage, stream and colour together
  always_ff @(posedge pclk) begin
    if (rst) begin
      vga_out       <= '0;
      vga_out.hblnk <= 1'b1;
      vga_out.vblnk <= 1'b1;
      rgb_out       <= `COLOR_BLANK;
    end else begin
      vga_out <= vga_in;
      rgb_out <= rgb_nxt;
    end
  end

endmodule

`default_nettype wire

/* src/draw_rect.sv */
// Rectangle painter
// overlays the paddle on the incoming picture, using a copy of the
// position taken once per frame so the image never tears

`timescale 1ns/100ps
`default_nettype none

`include "vga_defines.svh"

module draw_rect (
  input  logic               pclk,
  input  logic               rst,
  input  logic [10:0]        xpos,
  input  vga_pkg::vga_bus_t  vga_in,
  input  vga_pkg::rgb_t      rgb_in,
  output vga_pkg::vga_bus_t  vga_out,
  output vga_pkg::rgb_t      rgb_out
);

  logic [10:0]   xpos_frame;
  logic          frame_start;
  logic          in_cols;
  logic          in_rows;
  logic          active;
  vga_pkg::rgb_t rgb_nxt;

  assign frame_start = (vga_in.vcount == 11'd0) && (vga_in.hcount == 11'd0);

  // --------------------------------------------------
  // frame copy of the position
  always_ff @(posedge pclk) begin
    if (rst) begin
      xpos_frame <= 11'(`XPOS_RESET);
    end else if (frame_start) begin
      xpos_frame <= xpos;
    end
  end

  // --------------------------------------------------
  // rectangle hit test
  assign in_cols = (vga_in.hcount >= xpos_frame) &&
                   (vga_in.hcount < xpos_frame + 11'(`RECT_WIDTH));
  assign in_rows = (vga_in.vcount >= 11'(`RECT_YPOS)) &&
                   (vga_in.vcount < 11'(`RECT_YPOS + `RECT_HEIGHT));
  assign active  = !vga_in.hblnk && !vga_in.vblnk;

  always_comb begin
    if (active && in_cols && in_rows) begin
      rgb_nxt = `COLOR_RECT;
    end else begin
      rgb_nxt = rgb_in;
    end
  end

  // --------------------------------------------------
  // output stage
  always_ff @(posedge pclk) begin
    if (rst) begin
      vga_out       <= '0;
      vga_out.hblnk <= 1'b1;
      vga_out.vblnk <= 1'b1;
      rgb_out       <= `COLOR_BLANK;
    end else begin
      vga_out <= vga_in;
      rgb_out <= rgb_nxt;
    end
  end

endmodule

`default_nettype wire

/* src/position_rect_ctl.sv */
// Paddle position controller
// moves the paddle's left edge by one pixel per step period while a
// button is held, clamped to the allowed window

`timescale 1ns/100ps
`default_nettype none

`include "vga_defines.svh"

module position_rect_ctl #(
  parameter int step_div = `STEP_DIV_DEFAULT
) (
  input  logic        pclk,
  input  logic        rst,
  input  logic        left,
  input  logic        right,
  output logic [10:0] xpos
);

  localparam int cnt_w = (step_div > 1) ? $clog2(step_div) : 1;
  localparam logic [cnt_w-1:0] cnt_last = cnt_w'(step_div - 1);

  typedef enum logic [1:0] {
    idle,
    move_left,
    move_right
  } state_t;

  state_t            state;
  state_t            state_nxt;
  logic [cnt_w-1:0]  step_cnt;
  logic [cnt_w-1:0]  step_cnt_nxt;
  logic [10:0]       xpos_nxt;
  logic              step_hit;

  // --------------------------------------------------
  // next state
  // both buttons together count as no button
  always_comb begin
    if (left && !right) begin
      state_nxt = move_left;
    end else if (right && !left) begin
      state_nxt = move_right;
    end else begin
      state_nxt = idle;
    end
  end

  assign step_hit = (step_cnt == cnt_last);

  // --------------------------------------------------
  // step counter and position
  // counting only runs while the move continues, so the
  // release edge does not add a step
  always_comb begin
    step_cnt_nxt = '0;
    xpos_nxt     = xpos;
    if ((state != idle) && (state_nxt == state)) begin
      if (step_hit) begin
        if (state == move_left) begin
          xpos_nxt = (xpos <= 11'(`XPOS_MIN)) ? 11'(`XPOS_MIN) : xpos - 11'd1;
        end else begin
          xpos_nxt = (xpos >= 11'(`XPOS_MAX)) ? 11'(`XPOS_MAX) : xpos + 11'd1;
        end
      end else begin
        step_cnt_nxt = step_cnt + 1'b1;
      end
    end
  end

  // --------------------------------------------------
  // registers
  always_ff @(posedge pclk) begin
    if (rst) begin
      state    <= idle;
      step_cnt <= '0;
      xpos     <= 11'(`XPOS_RESET);
    end else begin
      state    <= state_nxt;
      step_cnt <= step_cnt_nxt;
      xpos     <= xpos_nxt;
    end
  end

endmodule

`default_nettype wire

/* src/vga_paddle_top.sv */
// VGA paddle display
// timing, background, button position control and paddle overlay
// chained into one 800x600 video output

`timescale 1ns/100ps
`default_nettype none

`include "vga_defines.svh"

module vga_paddle_top #(
  parameter int step_div = `STEP_DIV_DEFAULT
) (
  input  logic          pclk,
  input  logic          rst,
  input  logic          left,
  input  logic          right,
  output logic          hsync,
  output logic          vsync,
  output vga_pkg::rgb_t rgb,
  output logic [10:0]   hcount,
  output logic [10:0]   vcount,
  output logic [10:0]   xpos
);

  vga_pkg::vga_bus_t vga_tim;
  vga_pkg::vga_bus_t vga_bg;
  vga_pkg::vga_bus_t vga_rect;
  vga_pkg::rgb_t     rgb_bg;

  // --------------------------------------------------
  // video pipeline, two stages after the counters
  vga_timing u_vga_timing (
    .pclk    (pclk),
    .rst     (rst),
    .vga_out (vga_tim)
  );

  draw_background u_draw_background (
    .pclk    (pclk),
    .rst     (rst),
    .vga_in  (vga_tim),
    .vga_out (vga_bg),
    .rgb_out (rgb_bg)
  );

  draw_rect u_draw_rect (
    .pclk    (pclk),
    .rst     (rst),
    .xpos    (xpos),
    .vga_in  (vga_bg),
    .rgb_in  (rgb_bg),
    .vga_out (vga_rect),
    .rgb_out (rgb)
  );

  // --------------------------------------------------
  // paddle position
  position_rect_ctl #(
    .step_div (step_div)
  ) u_position_rect_ctl (
    .pclk  (pclk),
    .rst   (rst),
    .left  (left),
    .right (right),
    .xpos  (xpos)
  );

  // delayed counts belong to the rgb on the same clock
  assign hsync  = vga_rect.hsync;
  assign vsync  = vga_rect.vsync;
  assign hcount = vga_rect.hcount;
  assign vcount = vga_rect.vcount;

endmodule

`default_nettype wire

/* src/vga_pkg.sv */
// VGA paddle types
// colour word and the timing bundle that travels between the video stages

`default_nettype none

package vga_pkg;

  // --------------------------------------------------
  // one pixel colour, 4 bits per channel
  typedef struct packed {
    logic [3:0] r;
    logic [3:0] g;
    logic [3:0] b;
  } rgb_t;

  // --------------------------------------------------
  // timing bundle for one pixel
  // counts, syncs and blanks are always aligned to each other
  typedef struct packed {
    logic [10:0] hcount;
    logic [10:0] vcount;
    // positive polarity syncs
    logic        hsync;
    logic        vsync;
    // high outside the active area
    logic        hblnk;
    logic        vblnk;
  } vga_bus_t;

endpackage

`default_nettype wire

/* src/vga_timing.sv */
// VGA timing generator
// pixel and line counters for 800x600, with registered sync and blanking
// levels that stay aligned to the counts

`timescale 1ns/100ps
`default_nettype none

`include "vga_defines.svh"

module vga_timing (
  input  logic               pclk,
  input  logic               rst,
  output vga_pkg::vga_bus_t  vga_out
);

  // sync windows
  localparam int hs_start = `VGA_H_ACTIVE + `VGA_H_FP;
  localparam int hs_end   = hs_start + `VGA_H_SYNC;
  localparam int vs_start = `VGA_V_ACTIVE + `VGA_V_FP;
  localparam int vs_end   = vs_start + `VGA_V_SYNC;

  vga_pkg::vga_bus_t vga_q;
  logic [10:0] h_nxt;
  logic [10:0] v_nxt;
  logic        h_wrap;
  logic        v_wrap;

  // --------------------------------------------------
  // next counts
  always_comb begin
    h_wrap = (vga_q.hcount == 11'(`VGA_H_TOTAL - 1));
    v_wrap = (vga_q.vcount == 11'(`VGA_V_TOTAL - 1));
    h_nxt  = h_wrap ? 11'd0 : vga_q.hcount + 11'd1;
    if (h_wrap) begin
      v_nxt = v_wrap ? 11'd0 : vga_q.vcount + 11'd1;
    end else begin
      v_nxt = vga_q.vcount;
    end
  end

  // --------------------------------------------------
  // counters and levels, decoded from the next counts so
  // that they land in the same register stage
  always_ff @(posedge pclk) begin
    if (rst) begin
      vga_q <= '0;
    end else begin
      vga_q.hcount <= h_nxt;
      vga_q.vcount <= v_nxt;
      vga_q.hsync  <= (h_nxt >= 11'(hs_start)) && (h_nxt < 11'(hs_end));
      vga_q.vsync  <= (v_nxt >= 11'(vs_start)) && (v_nxt < 11'(vs_end));
      vga_q.hblnk  <= (h_nxt >= 11'(`VGA_H_ACTIVE));
      vga_q.vblnk  <= (v_nxt >= 11'(`VGA_V_ACTIVE));
    end
  end

  assign vga_out = vga_q;

endmodule

`default_nettype wire
